// ==== design/rv_core_pkg.sv ====
/*
  widths, reset pc, memory depth and opcodes shared by the rv64i subset core
  memory spans mem_depth doublewords from pc_reset, higher address bits are ignored
*/
package rv_core_pkg;

  // datapath and field widths
  localparam int unsigned xlen = 64;
  localparam int unsigned inst_width = 32;
  localparam int unsigned reg_id_width = 5;
  localparam int unsigned reg_count = 32;

  // local memory geometry
  localparam int unsigned mem_depth = 1024;
  localparam int unsigned mem_addr_width = $clog2(mem_depth);
  localparam int unsigned byte_count = xlen / 8;
  // byte address bits below the doubleword index
  localparam int unsigned dword_shift = 3;

  // every instruction is 4 bytes, no compressed forms
  localparam int unsigned inst_bytes = 4;

  typedef logic [xlen-1:0]           xlen_t;
  typedef logic [inst_width-1:0]     inst_t;
  typedef logic [reg_id_width-1:0]   reg_id_t;
  typedef logic [mem_addr_width-1:0] mem_addr_t;
  typedef logic [byte_count-1:0]     byte_mask_t;

  localparam xlen_t pc_reset = 64'h0000_0000_8000_0000;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    store  = 7'b0100011,
    system = 7'b1110011
  } opcode_e;

  // funct3 of addi / add, and of sd
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_sd  = 3'b011;
  localparam logic [6:0] funct7_add = 7'b0000000;

  // ebreak is one fixed word
  localparam inst_t ebreak_word = 32'h0010_0073;

  // byte address to doubleword index, relative to pc_reset
  function automatic mem_addr_t mem_index(input xlen_t addr);
    xlen_t offset;
    offset = addr - pc_reset;
    return offset[dword_shift +: mem_addr_width];
  endfunction

endpackage

// ==== design/unified_memory.sv ====
/*
  instruction and data memory in one doubleword array, no reset of contents
  fetch data appears one cycle after pc, loader write wins over a store
*/
module unified_memory (
  input  logic                    clk,
  input  logic                    load_en,
  input  rv_core_pkg::mem_addr_t  load_addr,
  input  rv_core_pkg::xlen_t      load_data,
  input  rv_core_pkg::xlen_t      pc,
  output rv_core_pkg::inst_t      inst,
  input  logic                    st_en,
  input  rv_core_pkg::xlen_t      st_addr,
  input  rv_core_pkg::xlen_t      st_data,
  input  rv_core_pkg::byte_mask_t st_mask
);
  import rv_core_pkg::*;

  xlen_t     mem [mem_depth];
  mem_addr_t fetch_idx;
  mem_addr_t st_idx;

  // address bits 12:3 pick the doubleword
  assign fetch_idx = mem_index(pc);
  assign st_idx    = mem_index(st_addr);

  // synchronous fetch
  // pc bit 2 selects upper or lower word
  always_ff @(posedge clk) begin
    if (pc[2]) begin
      inst <= mem[fetch_idx][inst_width +: inst_width];
    end else begin
      inst <= mem[fetch_idx][0 +: inst_width];
    end
  end

  // loader port, only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (st_en) begin
      // byte lanes enabled by mask
      for (int b = 0; b < byte_count; b++) begin
        if (st_mask[b]) begin
          mem[st_idx][b*8 +: 8] <= st_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== design/inst_decoder.sv ====
/*
  decodes addi, add, lui, auipc, jal, sd and ebreak only
  anything else flags illegal with every write strobe low
*/
module inst_decoder (
  input  rv_core_pkg::inst_t      inst,
  output rv_core_pkg::reg_id_t    rd,
  output rv_core_pkg::reg_id_t    rs1,
  output rv_core_pkg::reg_id_t    rs2,
  output rv_core_pkg::xlen_t      imm,
  output logic                    need_imm,
  output logic                    is_lui,
  output logic                    is_auipc,
  output logic                    is_jal,
  output logic                    is_ebreak,
  output logic                    reg_wen,
  output logic                    mem_wen,
  output rv_core_pkg::byte_mask_t wmask,
  output logic                    illegal
);
  import rv_core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_u;
  xlen_t      imm_j;

  // fixed field positions
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // immediates, all sign extended from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // default is an unknown word
    imm       = '0;
    need_imm  = 1'b0;
    is_lui    = 1'b0;
    is_auipc  = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    reg_wen   = 1'b0;
    mem_wen   = 1'b0;
    wmask     = '0;
    illegal   = 1'b1;
    case (opcode)
      op_imm: begin
        // addi only
        if (funct3 == funct3_add) begin
          imm      = imm_i;
          need_imm = 1'b1;
          reg_wen  = 1'b1;
          illegal  = 1'b0;
        end
      end
      op: begin
        // add only, sub and the rest rejected
        if (funct3 == funct3_add && funct7 == funct7_add) begin
          reg_wen = 1'b1;
          illegal = 1'b0;
        end
      end
      lui: begin
        imm      = imm_u;
        need_imm = 1'b1;
        is_lui   = 1'b1;
        reg_wen  = 1'b1;
        illegal  = 1'b0;
      end
      auipc: begin
        imm      = imm_u;
        need_imm = 1'b1;
        is_auipc = 1'b1;
        reg_wen  = 1'b1;
        illegal  = 1'b0;
      end
      jal: begin
        // offset goes to pc_ctrl, link value built in exec_unit
        imm     = imm_j;
        is_jal  = 1'b1;
        reg_wen = 1'b1;
        illegal = 1'b0;
      end
      store: begin
        // sd, full doubleword
        if (funct3 == funct3_sd) begin
          imm      = imm_s;
          need_imm = 1'b1;
          mem_wen  = 1'b1;
          wmask    = '1;
          illegal  = 1'b0;
        end
      end
      system: begin
        if (inst == ebreak_word) begin
          is_ebreak = 1'b1;
          illegal   = 1'b0;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== design/register_file.sv ====
/*
  32 x 64-bit integer registers, contents not reset
  x0 reads as zero and ignores writes
*/
module register_file (
  input  logic                 clk,
  input  logic                 wen,
  input  rv_core_pkg::reg_id_t rd,
  input  rv_core_pkg::xlen_t   wdata,
  input  rv_core_pkg::reg_id_t rs1,
  input  rv_core_pkg::reg_id_t rs2,
  output rv_core_pkg::xlen_t   rdata_1,
  output rv_core_pkg::xlen_t   rdata_2
);
  import rv_core_pkg::*;

  xlen_t regs [reg_count];

  // write at the end of the instruction cycle
  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  // x0 forced to zero here, entry 0 never written
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/exec_unit.sv ====
/*
  single adder datapath for addi, add, lui, auipc, jal link and sd address
*/
module exec_unit (
  input  rv_core_pkg::xlen_t current_pc,
  input  rv_core_pkg::xlen_t rdata_1,
  input  rv_core_pkg::xlen_t rdata_2,
  input  rv_core_pkg::xlen_t imm,
  input  logic               need_imm,
  input  logic               is_lui,
  input  logic               is_auipc,
  input  logic               is_jal,
  output rv_core_pkg::xlen_t wb_data,
  output rv_core_pkg::xlen_t st_addr,
  output rv_core_pkg::xlen_t st_data
);
  import rv_core_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t sum;

  // first operand
  // pc for auipc, zero for lui
  always_comb begin
    if (is_auipc) begin
      op_a = current_pc;
    end else if (is_lui) begin
      op_a = '0;
    end else begin
      op_a = rdata_1;
    end
  end

  assign op_b = need_imm ? imm : rdata_2;
  assign sum  = op_a + op_b;

  // jal links the following instruction
  assign wb_data = is_jal ? current_pc + xlen_t'(inst_bytes) : sum;

  // sd: base plus offset, data from rs2
  assign st_addr = sum;
  assign st_data = rdata_2;

endmodule

// ==== design/pc_ctrl.sv ====
/*
  pc register and next-pc select, halted and illegal stay set until reset
  run is low in reset and after a stop, so nothing retires then
*/
module pc_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               is_jal,
  input  rv_core_pkg::xlen_t imm,
  input  logic               is_ebreak,
  input  logic               illegal,
  output rv_core_pkg::xlen_t current_pc,
  output rv_core_pkg::xlen_t next_pc,
  output logic               run,
  output logic               halted,
  output logic               illegal_stop
);
  import rv_core_pkg::*;

  logic stopped;
  logic stop_now;

  assign stopped  = halted || illegal_stop;
  // the stopping instruction itself also holds the pc
  assign stop_now = stopped || is_ebreak || illegal;
  assign run      = !rst && !stopped;

  // memory fetches next_pc, so it must point at pc_reset during reset
  always_comb begin
    if (rst) begin
      next_pc = pc_reset;
    end else if (stop_now) begin
      next_pc = current_pc;
    end else if (is_jal) begin
      next_pc = current_pc + imm;
    end else begin
      next_pc = current_pc + xlen_t'(inst_bytes);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      current_pc   <= pc_reset;
      halted       <= 1'b0;
      illegal_stop <= 1'b0;
    end else begin
      current_pc <= next_pc;
      // sticky, first stop wins
      if (!stopped && is_ebreak) begin
        halted <= 1'b1;
      end
      if (!stopped && illegal) begin
        illegal_stop <= 1'b1;
      end
    end
  end

endmodule

// ==== design/core_top.sv ====
/*
  single-cycle rv64i subset core with local memory
  load the program only while rst is high, trace ports show each retired write
*/
module core_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_en,
  input  rv_core_pkg::mem_addr_t  load_addr,
  input  rv_core_pkg::xlen_t      load_data,
  output rv_core_pkg::xlen_t      current_pc,
  output logic                    halted,
  output logic                    illegal,
  output logic                    wb_en,
  output rv_core_pkg::reg_id_t    wb_rd,
  output rv_core_pkg::xlen_t      wb_data,
  output logic                    st_en,
  output rv_core_pkg::xlen_t      st_addr,
  output rv_core_pkg::xlen_t      st_data,
  output rv_core_pkg::byte_mask_t st_mask
);
  import rv_core_pkg::*;

  inst_t   inst;
  xlen_t   next_pc;
  reg_id_t rs1;
  reg_id_t rs2;
  xlen_t   imm;
  xlen_t   rdata_1;
  xlen_t   rdata_2;
  logic    need_imm;
  logic    is_lui;
  logic    is_auipc;
  logic    is_jal;
  logic    is_ebreak;
  logic    reg_wen;
  logic    mem_wen;
  logic    dec_illegal;
  logic    run;

  // retire strobes, blocked in reset and after a stop
  assign wb_en = reg_wen && run;
  assign st_en = mem_wen && run;

  unified_memory i_unified_memory (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (next_pc),
    .inst      (inst),
    .st_en     (st_en),
    .st_addr   (st_addr),
    .st_data   (st_data),
    .st_mask   (st_mask)
  );

  inst_decoder i_inst_decoder (
    .inst      (inst),
    .rd        (wb_rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .need_imm  (need_imm),
    .is_lui    (is_lui),
    .is_auipc  (is_auipc),
    .is_jal    (is_jal),
    .is_ebreak (is_ebreak),
    .reg_wen   (reg_wen),
    .mem_wen   (mem_wen),
    .wmask     (st_mask),
    .illegal   (dec_illegal)
  );

  register_file i_register_file (
    .clk     (clk),
    .wen     (wb_en),
    .rd      (wb_rd),
    .wdata   (wb_data),
    .rs1     (rs1),
    .rs2     (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  exec_unit i_exec_unit (
    .current_pc (current_pc),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .imm        (imm),
    .need_imm   (need_imm),
    .is_lui     (is_lui),
    .is_auipc   (is_auipc),
    .is_jal     (is_jal),
    .wb_data    (wb_data),
    .st_addr    (st_addr),
    .st_data    (st_data)
  );

  pc_ctrl i_pc_ctrl (
    .clk          (clk),
    .rst          (rst),
    .is_jal       (is_jal),
    .imm          (imm),
    .is_ebreak    (is_ebreak),
    .illegal      (dec_illegal),
    .current_pc   (current_pc),
    .next_pc      (next_pc),
    .run          (run),
    .halted       (halted),
    .illegal_stop (illegal)
  );

endmodule

// ==== test/tb_clock.sv ====
/*
  free-running 40 ns clock, rst high from time zero
  pulse_reset holds rst for 16 rising edges and drops it 1 ns after the last
*/
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 20;
  localparam int reset_cycles = 16;

  logic rst_q = 1'b1;

  assign rst = rst_q;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release lands between edges, like every other driven input
  task automatic pulse_reset();
    rst_q = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_q = 1'b0;
  endtask

endmodule

// ==== test/tb_checker.sv ====
/*
  compares the retire trace with the queued expected events in order
  samples on the falling edge and prints one result line per test
*/
module tb_checker (
  input logic                    clk,
  input logic                    rst,
  input logic                    halted,
  input logic                    illegal,
  input logic                    wb_en,
  input rv_core_pkg::reg_id_t    wb_rd,
  input rv_core_pkg::xlen_t      wb_data,
  input logic                    st_en,
  input rv_core_pkg::xlen_t      st_addr,
  input rv_core_pkg::xlen_t      st_data,
  input rv_core_pkg::byte_mask_t st_mask,
  input rv_core_pkg::xlen_t      current_pc
);
  timeunit 1ns;
  timeprecision 100ps;
  import rv_core_pkg::*;

  string test_name;
  // exp_is_st marks a store among the expected events
  logic  exp_is_st [$];
  xlen_t exp_a [$];
  xlen_t exp_d [$];
  int    test_errs;
  int    pass_count = 0;
  int    fail_count = 0;
  logic  stop_seen;
  xlen_t stop_pc;

  task automatic start_test(input string name);
    test_name = name;
    exp_is_st.delete();
    exp_a.delete();
    exp_d.delete();
    test_errs = 0;
    stop_seen = 1'b0;
  endtask

  // a holds rd for a register write or the byte address for a store
  task automatic expect_event(input logic is_st, input xlen_t a, input xlen_t d);
    exp_is_st.push_back(is_st);
    exp_a.push_back(a);
    exp_d.push_back(d);
  endtask

  function automatic string event_kind(input logic is_st);
    if (is_st) begin
      return "store";
    end else begin
      return "register write";
    end
  endfunction

  task automatic check_value(input string what, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic take_event(input logic is_st, input xlen_t a, input xlen_t d);
    logic  want_st;
    xlen_t want_a;
    xlen_t want_d;
    if (exp_is_st.size() == 0) begin
      $display("test %s: extra %s at pc %h, none was expected", test_name,
               event_kind(is_st), current_pc);
      test_errs++;
    end else begin
      want_st = exp_is_st.pop_front();
      want_a  = exp_a.pop_front();
      want_d  = exp_d.pop_front();
      if (want_st != is_st) begin
        $display("test %s: got a %s at pc %h where a %s was expected", test_name,
                 event_kind(is_st), current_pc, event_kind(want_st));
        test_errs++;
      end else if (is_st) begin
        check_value("st_addr", want_a, a);
        check_value("st_data", want_d, d);
      end else begin
        check_value("wb_rd", want_a, a);
        check_value("wb_data", want_d, d);
      end
    end
  endtask

  // sample mid-cycle when strobes and data have settled
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_en) begin
        take_event(1'b0, xlen_t'(wb_rd), wb_data);
      end
      if (st_en) begin
        take_event(1'b1, st_addr, st_data);
        // sd writes all eight bytes
        check_value("st_mask", xlen_t'(8'hff), xlen_t'(st_mask));
      end
      // pc frozen once either flag is up
      if (halted || illegal) begin
        if (!stop_seen) begin
          stop_seen = 1'b1;
          stop_pc   = current_pc;
        end else if (current_pc !== stop_pc) begin
          $display("test %s: pc moved from %h to %h after the core stopped",
                   test_name, stop_pc, current_pc);
          test_errs++;
        end
      end
    end
  end

  task automatic finish_test(input logic exp_illegal, input xlen_t exp_pc);
    if (exp_is_st.size() != 0) begin
      $display("test %s: %0d expected events never appeared", test_name, exp_is_st.size());
      test_errs++;
    end
    check_value("halted", xlen_t'(!exp_illegal), xlen_t'(halted));
    check_value("illegal", xlen_t'(exp_illegal), xlen_t'(illegal));
    check_value("end_pc", exp_pc, current_pc);
    if (test_errs == 0) begin
      pass_count++;
      $display("test %s pass", test_name);
    end else begin
      fail_count++;
      $display("test %s FAIL, %0d errors", test_name, test_errs);
    end
  endtask

endmodule

// ==== test/tb_top.sv ====
/*
  table-driven run of the core, each program loaded while rst is high
  programs fill four doublewords from pc_reset, unused words are ebreak
*/
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_core_pkg::*;

  localparam int num_tests = 6;
  localparam int max_words = 8;
  localparam int max_events = 8;
  localparam int reset_cycles = 16;
  localparam int settle_cycles = 4;
  localparam int unsigned seed = 65643;
  localparam inst_t ebreak_inst = 32'h0010_0073;

  logic       clk;
  logic       rst;
  logic       load_en;
  mem_addr_t  load_addr;
  xlen_t      load_data;
  xlen_t      current_pc;
  logic       halted;
  logic       illegal;
  logic       wb_en;
  reg_id_t    wb_rd;
  xlen_t      wb_data;
  logic       st_en;
  xlen_t      st_addr;
  xlen_t      st_data;
  byte_mask_t st_mask;

  // stimulus and expected-value table
  string t_name [num_tests];
  inst_t t_prog [num_tests][max_words];
  int    n_words [num_tests];
  logic  t_is_st [num_tests][max_events];
  xlen_t t_a [num_tests][max_events];
  xlen_t t_d [num_tests][max_events];
  int    n_ev [num_tests];
  logic  t_illegal [num_tests];
  xlen_t t_end_pc [num_tests];
  int    max_len;
  int    timeout_limit = 0;
  int    cycle_count = 0;

  tb_clock i_clock (
    .clk (clk),
    .rst (rst)
  );

  core_top i_core_top (
    .clk        (clk),
    .rst        (rst),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .current_pc (current_pc),
    .halted     (halted),
    .illegal    (illegal),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .st_en      (st_en),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .st_mask    (st_mask)
  );

  tb_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .halted     (halted),
    .illegal    (illegal),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .st_en      (st_en),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .st_mask    (st_mask),
    .current_pc (current_pc)
  );

  // rv64i encoders
  function automatic inst_t enc_addi(input reg_id_t rd, input reg_id_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // f7 zero is add, 0x20 is sub
  function automatic inst_t enc_r(input logic [6:0] f7, input reg_id_t rd,
                                  input reg_id_t rs1, input reg_id_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic inst_t enc_u(input logic [6:0] opc, input reg_id_t rd,
                                  input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t enc_jal(input reg_id_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic inst_t enc_sd(input reg_id_t rs2, input reg_id_t rs1,
                                   input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'b0100011};
  endfunction

  function automatic xlen_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  // u-type value on rv64, bit 31 sign extended
  function automatic xlen_t sext_u(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  function automatic xlen_t pc_at(input int word);
    return pc_reset + xlen_t'(4 * word);
  endfunction

  task automatic put_word(input int t, input inst_t w);
    t_prog[t][n_words[t]] = w;
    n_words[t]++;
  endtask

  task automatic put_event(input int t, input logic is_st, input xlen_t a, input xlen_t d);
    t_is_st[t][n_ev[t]] = is_st;
    t_a[t][n_ev[t]] = a;
    t_d[t][n_ev[t]] = d;
    n_ev[t]++;
  endtask

  task automatic build_table();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    xlen_t       x1;
    xlen_t       x2;
    xlen_t       x3;
    xlen_t       hi;
    for (int t = 0; t < num_tests; t++) begin
      n_words[t] = 0;
      n_ev[t] = 0;
      for (int w = 0; w < max_words; w++) begin
        t_prog[t][w] = ebreak_inst;
      end
    end
    imm_a = 12'($urandom());
    imm_b = 12'($urandom());
    imm_c = 12'($urandom());
    x1 = sext12(imm_a);
    x2 = x1 + sext12(imm_b);
    x3 = x1 + x2;

    // accumulate, then write x0 and read it back as zero
    t_name[0] = "addi_add";
    put_word(0, enc_addi(5'd1, 5'd0, imm_a));
    put_event(0, 1'b0, 64'd1, x1);
    put_word(0, enc_addi(5'd2, 5'd1, imm_b));
    put_event(0, 1'b0, 64'd2, x2);
    put_word(0, enc_r(7'h00, 5'd3, 5'd1, 5'd2));
    put_event(0, 1'b0, 64'd3, x3);
    put_word(0, enc_addi(5'd0, 5'd3, imm_c));
    put_event(0, 1'b0, 64'd0, x3 + sext12(imm_c));
    put_word(0, enc_r(7'h00, 5'd4, 5'd0, 5'd3));
    put_event(0, 1'b0, 64'd4, x3);
    put_word(0, enc_r(7'h00, 5'd5, 5'd3, 5'd0));
    put_event(0, 1'b0, 64'd5, x3);
    t_illegal[0] = 1'b0;
    t_end_pc[0] = pc_at(6);

    t_name[1] = "lui_auipc";
    put_word(1, enc_u(7'b0110111, 5'd6, 20'h12345));
    put_event(1, 1'b0, 64'd6, sext_u(20'h12345));
    put_word(1, enc_u(7'b0110111, 5'd7, 20'hfedcb));
    put_event(1, 1'b0, 64'd7, sext_u(20'hfedcb));
    put_word(1, enc_u(7'b0010111, 5'd8, 20'h00010));
    put_event(1, 1'b0, 64'd8, pc_at(2) + sext_u(20'h00010));
    // negative offset wraps pc down to a small value
    put_word(1, enc_u(7'b0010111, 5'd9, 20'h80000));
    put_event(1, 1'b0, 64'd9, pc_at(3) + sext_u(20'h80000));
    t_illegal[1] = 1'b0;
    t_end_pc[1] = pc_at(4);

    // words 2, 3 and 5 are jumped over
    t_name[2] = "jal";
    put_word(2, enc_addi(5'd10, 5'd0, 12'h005));
    put_event(2, 1'b0, 64'd10, 64'd5);
    put_word(2, enc_jal(5'd1, 21'd12));
    put_event(2, 1'b0, 64'd1, pc_at(2));
    put_word(2, enc_addi(5'd11, 5'd0, 12'h001));
    put_word(2, enc_addi(5'd12, 5'd0, 12'h002));
    put_word(2, enc_jal(5'd13, 21'd8));
    put_event(2, 1'b0, 64'd13, pc_at(5));
    put_word(2, enc_addi(5'd14, 5'd0, 12'h003));
    t_illegal[2] = 1'b0;
    t_end_pc[2] = pc_at(6);

    // stores land well clear of the program doublewords
    hi = sext_u(20'habcde);
    t_name[3] = "sd";
    put_word(3, enc_addi(5'd15, 5'd0, 12'h100));
    put_event(3, 1'b0, 64'd15, 64'h100);
    put_word(3, enc_u(7'b0110111, 5'd16, 20'habcde));
    put_event(3, 1'b0, 64'd16, hi);
    put_word(3, enc_addi(5'd16, 5'd16, 12'h123));
    put_event(3, 1'b0, 64'd16, hi + 64'h123);
    put_word(3, enc_sd(5'd16, 5'd15, 12'h008));
    put_event(3, 1'b1, 64'h108, hi + 64'h123);
    put_word(3, enc_sd(5'd0, 5'd15, 12'hff8));
    put_event(3, 1'b1, 64'h100 + sext12(12'hff8), 64'd0);
    t_illegal[3] = 1'b0;
    t_end_pc[3] = pc_at(5);

    t_name[4] = "ebreak";
    put_word(4, enc_addi(5'd17, 5'd0, 12'h007));
    put_event(4, 1'b0, 64'd17, 64'd7);
    put_word(4, ebreak_inst);
    put_word(4, enc_addi(5'd18, 5'd0, 12'h009));
    t_illegal[4] = 1'b0;
    t_end_pc[4] = pc_at(1);

    // sub is outside the subset
    t_name[5] = "illegal";
    put_word(5, enc_addi(5'd19, 5'd0, 12'h003));
    put_event(5, 1'b0, 64'd19, 64'd3);
    put_word(5, enc_r(7'h20, 5'd20, 5'd0, 5'd0));
    put_word(5, enc_addi(5'd20, 5'd0, 12'h001));
    t_illegal[5] = 1'b1;
    t_end_pc[5] = pc_at(1);

    max_len = 0;
    for (int t = 0; t < num_tests; t++) begin
      if (n_words[t] > max_len) begin
        max_len = n_words[t];
      end
    end
  endtask

  // lower word of each doubleword is the lower address
  task automatic load_program(input int t);
    for (int d = 0; d < max_words / 2; d++) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = mem_addr_t'(d);
      load_data = {t_prog[t][2*d+1], t_prog[t][2*d]};
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles, the core never stopped", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(seed));
    build_table();
    // reset, run and settle per test
    timeout_limit = num_tests * (reset_cycles + 16 + max_len);
    for (int t = 0; t < num_tests; t++) begin
      i_checker.start_test(t_name[t]);
      for (int e = 0; e < n_ev[t]; e++) begin
        i_checker.expect_event(t_is_st[t][e], t_a[t][e], t_d[t][e]);
      end
      fork
        i_clock.pulse_reset();
        load_program(t);
      join
      do begin
        @(posedge clk);
        #1;
      end while (!(halted || illegal));
      // a few more cycles to catch stray events or pc motion
      repeat (settle_cycles) @(posedge clk);
      #1;
      i_checker.finish_test(t_illegal[t], t_end_pc[t]);
    end
    $display("tests %0d, passed %0d, failed %0d", num_tests,
             i_checker.pass_count, i_checker.fail_count);
    if (i_checker.fail_count == 0 && i_checker.pass_count == num_tests) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/rv_core_pkg.sv
design/unified_memory.sv
design/inst_decoder.sv
design/register_file.sv
design/exec_unit.sv
design/pc_ctrl.sv
design/core_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_top
FILELIST  := filelist.f
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
